//--- rtl/soc_pkg.sv
// Shared definitions for the accumulator SoC
// Widths, instruction encoding, bus structs, address map and boot program constants
package soc_pkg;

  // Word and field widths
  localparam int DATA_W = 16;
  localparam int ADDR_W = 12;
  localparam int OPC_W  = 4;
  localparam int LED_W  = 10;
  localparam int SW_W   = 10;

  // Memory windows are the same size for ROM and RAM
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LED_W-1:0]  led_t;
  typedef logic [SW_W-1:0]   sw_t;
  typedef logic [MEM_AW-1:0] offset_t;

  // Opcode in bits [15:12], operand address in [11:0]
  // Zero word decodes as NOP, so blank ROM is harmless
  typedef enum logic [OPC_W-1:0] {
    OP_NOP = 4'h0,
    OP_LD  = 4'h1,
    OP_ST  = 4'h2,
    OP_ADD = 4'h3,
    OP_JMP = 4'h4
  } opcode_t;

  // Processor to decoder, one strobe per access
  typedef struct packed {
    logic  rd_stb;
    logic  wr_stb;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Decoder to one memory
  typedef struct packed {
    logic    en;
    logic    we;
    offset_t offset;
    data_t   wdata;
  } mem_req_t;

  typedef enum logic [1:0] {ST_FETCH, ST_DECODE, ST_EXEC, ST_WB} cpu_state_t;

  // Address map
  localparam addr_t ROM_BASE    = 12'h000;
  localparam addr_t RAM_BASE    = 12'h400;
  localparam addr_t IO_SW_ADDR  = 12'h800;
  localparam addr_t IO_LED_ADDR = 12'h801;

  // Boot program data
  localparam addr_t ROM_CONST_ADDR = 12'h010;
  localparam data_t ROM_CONST      = 16'h0015;
  localparam addr_t UNMAPPED_ADDR  = 12'h600;

endpackage

//--- rtl/soc_cpu.sv
// Multicycle accumulator processor
// Four cycles per instruction: fetch strobe, decode, operand strobe, write-back.
// Read data is expected exactly one cycle after each read strobe
`timescale 1ns/10ps

module soc_cpu import soc_pkg::*; (
  input  logic     i_clock,
  input  logic     i_rst_n,
  output bus_req_t o_bus,
  input  data_t    i_rdata
);

  cpu_state_t state;

  // Architectural state
  addr_t pc;
  data_t acc;

  // Only the opcode is needed after decode
  opcode_t op_q;

  // Registered bus request, strobes last one cycle
  bus_req_t bus_q;

  // Fields of the instruction word arriving in decode
  opcode_t dec_op;
  addr_t   dec_arg;

  assign dec_op  = opcode_t'(i_rdata[DATA_W-1 -: OPC_W]);
  assign dec_arg = i_rdata[ADDR_W-1:0];

  assign o_bus = bus_q;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      // Start in write-back with a NOP pending
      // so the first fetch strobe follows reset release
      state <= ST_WB;
      pc    <= '0;
      acc   <= '0;
      op_q  <= OP_NOP;
      bus_q <= '0;
    end else begin
      // Strobes drop unless set below
      bus_q.rd_stb <= 1'b0;
      bus_q.wr_stb <= 1'b0;

      unique case (state)
        ST_FETCH: begin
          // ROM read in flight
          state <= ST_DECODE;
        end

        ST_DECODE: begin
          op_q  <= dec_op;
          pc    <= pc + 1'b1;
          state <= ST_EXEC;
          case (dec_op)
            OP_LD, OP_ADD: begin
              bus_q.rd_stb <= 1'b1;
              bus_q.addr   <= dec_arg;
            end
            OP_ST: begin
              bus_q.wr_stb <= 1'b1;
              bus_q.addr   <= dec_arg;
              bus_q.wdata  <= acc;
            end
            OP_JMP: begin
              // Overrides the increment above
              pc <= dec_arg;
            end
            default: begin
              // NOP, no access
            end
          endcase
        end

        ST_EXEC: begin
          // Operand read in flight, or store done
          state <= ST_WB;
        end

        ST_WB: begin
          case (op_q)
            OP_LD: begin
              acc <= i_rdata;
            end
            OP_ADD: begin
              // Wraps modulo 2^16
              acc <= acc + i_rdata;
            end
            default: begin
              // Nothing to retire
            end
          endcase
          // Next fetch
          bus_q.rd_stb <= 1'b1;
          bus_q.addr   <= pc;
          state        <= ST_FETCH;
        end

        default: begin
          state <= ST_WB;
        end
      endcase
    end
  end

endmodule

//--- rtl/soc_brom.sv
// Boot ROM with the fixed program and its constant
// Synchronous read, data one cycle after enable
`timescale 1ns/10ps

module soc_brom import soc_pkg::*; (
  input  logic     i_clock,
  input  mem_req_t i_req,
  output data_t    o_rdata
);

  // Program image
  // LED result is 3 * switches + ROM_CONST
  function automatic data_t rom_word(input offset_t a);
    data_t w;
    case (a)
      // Switches into the accumulator
      8'h00: w = {OP_LD, IO_SW_ADDR};
      // Scratch copy in RAM
      8'h01: w = {OP_ST, RAM_BASE};
      // Two adds of the copy give three times the switches
      8'h02: w = {OP_ADD, RAM_BASE};
      8'h03: w = {OP_ADD, RAM_BASE};
      // Hole in the map, adds zero
      8'h04: w = {OP_ADD, UNMAPPED_ADDR};
      8'h05: w = {OP_ADD, ROM_CONST_ADDR};
      8'h06: w = {OP_ST, IO_LED_ADDR};
      8'h07: w = {OP_JMP, ROM_BASE};
      // Constant word
      ROM_CONST_ADDR[MEM_AW-1:0]: w = ROM_CONST;
      default: w = '0;
    endcase
    return w;
  endfunction

  // Writes are ignored, the decoder only sends reads here
  always_ff @(posedge i_clock) begin
    if (i_req.en && !i_req.we) begin
      o_rdata <= rom_word(i_req.offset);
    end
  end

endmodule

//--- rtl/soc_bram.sv
// Scratch block RAM, 256 words
// Write when enabled with we, registered read otherwise
`timescale 1ns/10ps

module soc_bram import soc_pkg::*; (
  input  logic     i_clock,
  input  mem_req_t i_req,
  output data_t    o_rdata
);

  // Storage
  data_t mem [MEM_WORDS];

  // Single port, one access per cycle
  always_ff @(posedge i_clock) begin
    if (i_req.en) begin
      if (i_req.we) begin
        mem[i_req.offset] <= i_req.wdata;
      end else begin
        // Read data holds until the next read
        o_rdata <= mem[i_req.offset];
      end
    end
  end

endmodule

//--- rtl/soc_bus_decode.sv
// Address decoder and read-data multiplexer
// Steers processor strobes to ROM, RAM or IO and returns read data a cycle later.
// Also holds the switch sampling register and the LED output register
`timescale 1ns/10ps

module soc_bus_decode import soc_pkg::*; (
  input  logic     i_clock,
  input  logic     i_rst_n,
  input  bus_req_t i_bus,
  output data_t    o_rdata,
  output mem_req_t o_rom_req,
  input  data_t    i_rom_rdata,
  output mem_req_t o_ram_req,
  input  data_t    i_ram_rdata,
  input  sw_t      i_sw,
  output led_t     o_led,
  output logic     o_led_stb
);

  // Region hits for the current address
  logic hit_rom;
  logic hit_ram;
  logic hit_sw;
  logic hit_led;

  // Region of the read in flight
  logic sel_rom_q;
  logic sel_ram_q;
  logic sel_sw_q;

  sw_t   sw_q;
  data_t sw_rdata_q;

  // ROM and RAM windows compare the upper address bits only
  assign hit_rom = i_bus.addr[ADDR_W-1:MEM_AW] == ROM_BASE[ADDR_W-1:MEM_AW];
  assign hit_ram = i_bus.addr[ADDR_W-1:MEM_AW] == RAM_BASE[ADDR_W-1:MEM_AW];
  assign hit_sw  = i_bus.addr == IO_SW_ADDR;
  assign hit_led = i_bus.addr == IO_LED_ADDR;

  // ROM sees reads only
  assign o_rom_req.en     = i_bus.rd_stb && hit_rom;
  assign o_rom_req.we     = 1'b0;
  assign o_rom_req.offset = i_bus.addr[MEM_AW-1:0];
  assign o_rom_req.wdata  = '0;

  assign o_ram_req.en     = (i_bus.rd_stb || i_bus.wr_stb) && hit_ram;
  assign o_ram_req.we     = i_bus.wr_stb;
  assign o_ram_req.offset = i_bus.addr[MEM_AW-1:0];
  assign o_ram_req.wdata  = i_bus.wdata;

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      sel_rom_q <= 1'b0;
      sel_ram_q <= 1'b0;
      sel_sw_q  <= 1'b0;
      sw_q      <= '0;
      o_led     <= '0;
      o_led_stb <= 1'b0;
    end else begin
      // Selection lives one cycle, matching the memory latency
      sel_rom_q <= i_bus.rd_stb && hit_rom;
      sel_ram_q <= i_bus.rd_stb && hit_ram;
      sel_sw_q  <= i_bus.rd_stb && hit_sw;
      // Switches sampled every cycle
      sw_q      <= i_sw;
      // LED update, strobe marks the new value
      o_led_stb <= i_bus.wr_stb && hit_led;
      if (i_bus.wr_stb && hit_led) begin
        o_led <= i_bus.wdata[LED_W-1:0];
      end
    end
  end

  // Switch value captured at the read strobe
  always_ff @(posedge i_clock) begin
    if (i_bus.rd_stb && hit_sw) begin
      sw_rdata_q <= {{(DATA_W-SW_W){1'b0}}, sw_q};
    end
  end

  // Unmapped reads fall through to zero
  assign o_rdata = sel_rom_q ? i_rom_rdata :
                   sel_ram_q ? i_ram_rdata :
                   sel_sw_q  ? sw_rdata_q  :
                   '0;

endmodule

//--- rtl/soc_top.sv
// Top level of the accumulator SoC
// Processor, boot ROM and scratch RAM joined through the bus decoder,
// switches in and red LEDs out
`timescale 1ns/10ps

module soc_top import soc_pkg::*; (
  input  logic i_clock,
  input  logic i_rst_n,
  input  sw_t  i_sw,
  output led_t o_led,
  output logic o_led_stb
);

  // Processor bus
  bus_req_t cpu_bus;
  data_t    cpu_rdata;

  // Memory side
  mem_req_t rom_req;
  data_t    rom_rdata;
  mem_req_t ram_req;
  data_t    ram_rdata;

  soc_cpu u_cpu (
    .i_clock (i_clock),
    .i_rst_n (i_rst_n),
    .o_bus   (cpu_bus),
    .i_rdata (cpu_rdata)
  );

  soc_brom u_rom (
    .i_clock (i_clock),
    .i_req   (rom_req),
    .o_rdata (rom_rdata)
  );

  soc_bram u_ram (
    .i_clock (i_clock),
    .i_req   (ram_req),
    .o_rdata (ram_rdata)
  );

  soc_bus_decode u_decode (
    .i_clock     (i_clock),
    .i_rst_n     (i_rst_n),
    .i_bus       (cpu_bus),
    .o_rdata     (cpu_rdata),
    .o_rom_req   (rom_req),
    .i_rom_rdata (rom_rdata),
    .o_ram_req   (ram_req),
    .i_ram_rdata (ram_rdata),
    .i_sw        (i_sw),
    .o_led       (o_led),
    .o_led_stb   (o_led_stb)
  );

endmodule

//--- test/soc_asserts.sv
// Bus and LED strobe properties for the SoC top level
// Bound into soc_top, sees the processor bus directly
`timescale 1ns/10ps

module soc_asserts import soc_pkg::*; (
  input logic     i_clock,
  input logic     i_rst_n,
  input bus_req_t i_bus,
  input logic     i_led_stb
);

  // One access per strobe cycle
  a_one_strobe: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    !(i_bus.rd_stb && i_bus.wr_stb))
    else $error("read and write strobes high together");

  // LED strobe is a single-cycle pulse
  a_led_pulse: assert property (@(posedge i_clock) disable iff (!i_rst_n)
    i_led_stb |=> !i_led_stb)
    else $error("LED strobe high for two cycles");

  // Sampled mid-cycle so reset values have settled
  a_quiet_reset: assert property (@(negedge i_clock)
    !i_rst_n |-> !(i_bus.rd_stb || i_bus.wr_stb || i_led_stb))
    else $error("strobe active during reset");

endmodule

bind soc_top soc_asserts u_asserts (
  .i_clock   (i_clock),
  .i_rst_n   (i_rst_n),
  .i_bus     (cpu_bus),
  .i_led_stb (o_led_stb)
);

//--- test/tb_soc.sv
// Testbench for the accumulator SoC
// Drives the switches, follows the LED strobe and checks each result
// against 3 * switches + 0x015 modulo 1024
`timescale 1ns/10ps

module tb_soc import soc_pkg::*; ();

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS    = 40;
  localparam int HOLD_STROBES = 3;
  localparam int SEED         = 96294;

  // LED result rule, offset and modulus
  localparam int unsigned LED_OFFSET = 32'h015;
  localparam int unsigned LED_MOD    = 1024;

  logic i_clock = 1'b0;
  logic i_rst_n;
  sw_t  i_sw;
  led_t o_led;
  logic o_led_stb;

  // Checker control from the stimulus process
  logic check_armed;
  logic hold_armed;
  led_t exp_led;

  // Checker state
  logic seen_strobe;
  led_t prev_led;
  int   errors;
  int   checks;

  soc_top u_soc_top (
    .i_clock   (i_clock),
    .i_rst_n   (i_rst_n),
    .i_sw      (i_sw),
    .o_led     (o_led),
    .o_led_stb (o_led_stb)
  );

  always #HALF_PERIOD i_clock = ~i_clock;

  // Expected LED value for a switch setting
  function automatic led_t expected_led(input sw_t sw);
    int unsigned sum;
    sum = 32'd3 * 32'(sw) + LED_OFFSET;
    return led_t'(sum % LED_MOD);
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Returns at the falling edge where the strobe is seen
  task automatic wait_strobe();
    do begin
      @(negedge i_clock);
    end while (!o_led_stb);
  endtask

  // New switch value, first strobe skipped and the next one checked
  task automatic apply_and_check(input sw_t sw);
    @(posedge i_clock);
    i_sw <= sw;
    check_armed = 1'b0;
    // Old value may still be in flight
    wait_strobe();
    @(posedge i_clock);
    exp_led = expected_led(sw);
    check_armed = 1'b1;
    wait_strobe();
  endtask

  // Compare process on the falling edge where outputs are stable
  always @(negedge i_clock) begin
    if (!i_rst_n) begin
      check_equal("o_led during reset", 32'(o_led), 32'd0);
      check_equal("o_led_stb during reset", 32'(o_led_stb), 32'd0);
    end else if (!o_led_stb && !seen_strobe) begin
      // LED stays clear until the first result
      check_equal("o_led before first strobe", 32'(o_led), 32'd0);
    end
    if (i_rst_n && o_led_stb) begin
      if (check_armed) begin
        check_equal("o_led on strobe", 32'(o_led), 32'(exp_led));
      end
      if (hold_armed) begin
        check_equal("o_led with switches held", 32'(o_led), 32'(prev_led));
      end
      prev_led    = o_led;
      seen_strobe = 1'b1;
    end
  end

  initial begin
    i_rst_n     = 1'b0;
    i_sw        = '0;
    check_armed = 1'b0;
    hold_armed  = 1'b0;
    exp_led     = '0;
    seen_strobe = 1'b0;
    prev_led    = '0;
    errors      = 0;
    checks      = 0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) @(posedge i_clock);
    i_rst_n <= 1'b1;

    // First loop with switches at zero
    exp_led     = expected_led('0);
    check_armed = 1'b1;
    wait_strobe();

    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_and_check(sw_t'($urandom));
    end

    // All ones so the sum wraps past 1024
    apply_and_check(10'h3FF);

    // Value must repeat while the switches stay put
    @(posedge i_clock);
    hold_armed = 1'b1;
    repeat (HOLD_STROBES) wait_strobe();

    @(posedge i_clock);
    check_armed = 1'b0;
    hold_armed  = 1'b0;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Budget of a few program loops per test
  initial begin
    repeat ((NUM_TESTS + 4) * 200) @(posedge i_clock);
    $display("timeout: LED strobe never arrived, checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- flist.f
rtl/soc_pkg.sv
rtl/soc_cpu.sv
rtl/soc_brom.sv
rtl/soc_bram.sv
rtl/soc_bus_decode.sv
rtl/soc_top.sv
test/soc_asserts.sv
test/tb_soc.sv

//--- Makefile
# Verilator build and run of the SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
